/* source/host_pkg.sv */
package host_pkg;

  // uart bit timing, scaled down for simulation
  localparam int clks_per_bit = 16;

  // memory bus
  localparam int addr_width = 10;                            // byte address
  localparam logic [addr_width-1:0] load_base = 10'h200;     // first program word
  localparam logic [addr_width-1:0] io_addr = 10'd2;         // uart data register
  localparam logic [15:0] end_word = 16'hffff;               // load terminator

  // led matrix scan timing
  localparam int row_period = 64;
  localparam int gap_on = 4;   // dark clocks at the start of a row
  localparam int gap_off = 8;  // dark clocks at the end of a row
  localparam int num_rows = 6;

  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } byte_pair_t;

  // one memory word, seen as an instruction/data word or as two bytes
  typedef union packed {
    logic [15:0] word;
    byte_pair_t  bytes;
  } mem_word_t;

  // single write request, loader or cpu side
  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] addr;
    mem_word_t             data;
  } wr_req_t;

  // status handed to the led scanner
  typedef struct packed {
    mem_word_t             wr_data;
    logic [addr_width-1:0] wr_addr;
    mem_word_t             rx_word;
    logic                  run;
    logic                  tx_credit;
  } disp_t;

endpackage

/* source/led_matrix_scan.sv */
module led_matrix_scan import host_pkg::*; (
  input  logic                sys_clk,
  input  logic                rst_n,
  input  disp_t               disp,
  output logic [7:0]          led_col,
  output logic [num_rows-1:0] led_row
);

  logic [$clog2(row_period)-1:0] cnt;
  logic [$clog2(num_rows)-1:0] row_idx;
  logic row_on;

  // segments a..g in bits 7:1, dot in bit 0
  function automatic logic [7:0] encode_7seg(input logic [3:0] n, input logic dot);
    logic [6:0] seg;
    case (n)
      4'h0: seg = 7'b1111110;
      4'h1: seg = 7'b0110000;
      4'h2: seg = 7'b1101101;
      4'h3: seg = 7'b1111001;
      4'h4: seg = 7'b0110011;
      4'h5: seg = 7'b1011011;
      4'h6: seg = 7'b1011111;
      4'h7: seg = 7'b1110000;
      4'h8: seg = 7'b1111111;
      4'h9: seg = 7'b1111011;
      4'ha: seg = 7'b1110111;
      4'hb: seg = 7'b0011111;
      4'hc: seg = 7'b1001110;
      4'hd: seg = 7'b0111101;
      4'he: seg = 7'b1001111;
      default: seg = 7'b1000111;  // f
    endcase
    return {seg, dot};
  endfunction

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
      row_idx <= '0;
    end else if (cnt == row_period - 1) begin
      cnt <= '0;
      // next row on wrap
      if (row_idx == num_rows - 1) row_idx <= '0;
      else row_idx <= row_idx + 1'b1;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // blanking around the row change avoids ghosting
  assign row_on = (cnt >= gap_on) && (cnt < row_period - gap_off);
  assign led_row = row_on ? (num_rows'(1) << row_idx) : '0;

  always_comb begin
    case (row_idx)
      0: led_col = disp.wr_data.bytes.hi;
      1: led_col = disp.wr_data.bytes.lo;
      2: led_col = disp.rx_word.bytes.hi;
      3: led_col = disp.rx_word.bytes.lo;
      4: led_col = encode_7seg(disp.wr_addr[4:1], disp.wr_addr[5]);  // word index digit
      5: led_col = {6'b0, disp.run, disp.tx_credit};
      default: led_col = 8'h00;
    endcase
  end

endmodule

/* source/loader_top.sv */
module loader_top import host_pkg::*; (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  input  logic                  uart_rx,
  output logic                  uart_tx,
  output logic [7:0]            led_col,
  output logic [num_rows-1:0]   led_row,
  input  wr_req_t               cpu_req,
  input  logic [addr_width-1:0] cpu_rd_addr,
  output mem_word_t             cpu_rd_data,
  output logic                  run,
  output logic                  tx_credit
);

  logic [7:0] rx_byte;
  logic rx_valid;
  wr_req_t load_req;
  mem_word_t rx_word;
  logic rx_word_valid;
  logic tx_start;
  logic [7:0] tx_byte;
  logic tx_done;
  disp_t disp;

  uart_rx u_rx (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .rx      (uart_rx),
    .rx_byte (rx_byte),
    .rx_valid(rx_valid)
  );

  // bytes to words, load writes until the terminator
  program_loader u_loader (
    .sys_clk      (sys_clk),
    .rst_n        (rst_n),
    .rx_byte      (rx_byte),
    .rx_valid     (rx_valid),
    .load_req     (load_req),
    .run          (run),
    .rx_word      (rx_word),
    .rx_word_valid(rx_word_valid)
  );

  mem_port_arbiter u_arbiter (
    .sys_clk      (sys_clk),
    .rst_n        (rst_n),
    .run          (run),
    .load_req     (load_req),
    .cpu_req      (cpu_req),
    .cpu_rd_addr  (cpu_rd_addr),
    .rx_word      (rx_word),
    .rx_word_valid(rx_word_valid),
    .cpu_rd_data  (cpu_rd_data),
    .tx_start     (tx_start),
    .tx_byte      (tx_byte),
    .tx_done      (tx_done),
    .tx_credit    (tx_credit),
    .disp         (disp)
  );

  uart_tx u_tx (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .tx_start(tx_start),
    .tx_byte (tx_byte),
    .tx      (uart_tx),
    .tx_done (tx_done)
  );

  led_matrix_scan u_scan (
    .sys_clk(sys_clk),
    .rst_n  (rst_n),
    .disp   (disp),
    .led_col(led_col),
    .led_row(led_row)
  );

endmodule

/* source/mem_port_arbiter.sv */
module mem_port_arbiter import host_pkg::*; (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  input  logic                  run,
  input  wr_req_t               load_req,
  input  wr_req_t               cpu_req,
  input  logic [addr_width-1:0] cpu_rd_addr,
  input  mem_word_t             rx_word,
  input  logic                  rx_word_valid,
  output mem_word_t             cpu_rd_data,
  output logic                  tx_start,
  output logic [7:0]            tx_byte,
  input  logic                  tx_done,
  output logic                  tx_credit,
  output disp_t                 disp
);

  mem_word_t ram [0:(1 << (addr_width - 1)) - 1];  // 512 words
  wr_req_t wr;                                    // active write stream
  mem_word_t rd_word;
  logic [addr_width-1:0] rd_addr_q;
  mem_word_t io_reg;
  logic io_wr;
  logic tx_accept;
  mem_word_t last_data;
  logic [addr_width-1:0] last_addr;

  // loader owns the ram until run, then the cpu does
  assign wr = run ? cpu_req : load_req;

  assign io_wr = wr.valid && (wr.addr == io_addr);
  assign tx_accept = run && io_wr && tx_credit;  // dropped without credit

  always_ff @(posedge sys_clk) begin
    if (wr.valid && !io_wr) ram[wr.addr[addr_width-1:1]] <= wr.data;
    rd_word <= ram[cpu_rd_addr[addr_width-1:1]];
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr_q <= '0;
    end else begin
      rd_addr_q <= cpu_rd_addr;
    end
  end

  // io register shadows the ram at io_addr
  assign cpu_rd_data = (rd_addr_q == io_addr) ? io_reg : rd_word;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      io_reg <= '0;
    end else if (rx_word_valid) begin
      io_reg <= rx_word;
    end
  end

  // single transmit credit
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_credit <= 1'b1;
      tx_start <= 1'b0;
    end else begin
      tx_start <= tx_accept;
      if (tx_accept) tx_credit <= 1'b0;
      else if (tx_done) tx_credit <= 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (tx_accept) tx_byte <= wr.data.bytes.lo;
  end

  // last write of either stream, for the display
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      last_data <= '0;
      last_addr <= '0;
    end else if (wr.valid) begin
      last_data <= wr.data;
      last_addr <= wr.addr;
    end
  end

  always_comb begin
    disp.wr_data = last_data;
    disp.wr_addr = last_addr;
    disp.rx_word = io_reg;
    disp.run = run;
    disp.tx_credit = tx_credit;
  end

endmodule

/* source/program_loader.sv */
module program_loader import host_pkg::*; (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic [7:0] rx_byte,
  input  logic       rx_valid,
  output wr_req_t    load_req,
  output logic       run,
  output mem_word_t  rx_word,
  output logic       rx_word_valid
);

  logic phase;       // 0 waits for the high byte, 1 for the low byte
  mem_word_t pack;   // last two bytes received
  logic word_done;   // pack holds a fresh word this cycle
  logic is_end;
  logic [addr_width-1:0] load_addr;

  assign is_end = (pack.word == end_word);
  assign rx_word = pack;
  assign rx_word_valid = word_done;

  // terminator word is never written
  always_comb begin
    load_req.valid = word_done && !run && !is_end;
    load_req.addr = load_addr;
    load_req.data = pack;
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= 1'b0;
      word_done <= 1'b0;
    end else begin
      if (rx_valid) phase <= ~phase;
      word_done <= rx_valid && phase;
    end
  end

  // high byte first
  always_ff @(posedge sys_clk) begin
    if (rx_valid) begin
      pack.bytes.hi <= pack.bytes.lo;
      pack.bytes.lo <= rx_byte;
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      load_addr <= load_base;
    end else if (load_req.valid) begin
      load_addr <= load_addr + addr_width'(2);  // next word
    end
  end

  // sticky until reset, no reload once the program runs
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      run <= 1'b0;
    end else if (word_done && is_end) begin
      run <= 1'b1;
    end
  end

endmodule

/* source/uart_rx.sv */
module uart_rx import host_pkg::*; (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  typedef enum logic [1:0] {
    s_idle,
    s_start,
    s_data,
    s_stop
  } state_t;

  state_t state;
  logic [1:0] rx_sync;  // two-flop synchronizer
  logic rx_s;
  logic [$clog2(clks_per_bit)-1:0] baud_cnt;
  logic [2:0] bit_idx;
  logic [7:0] shift_reg;

  assign rx_s = rx_sync[1];
  assign rx_byte = shift_reg;  // stable once the frame is done

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= 2'b11;
    end else begin
      rx_sync <= {rx_sync[0], rx};
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= s_idle;
      baud_cnt <= '0;
      bit_idx <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        s_idle: begin
          baud_cnt <= '0;
          if (!rx_s) state <= s_start;  // falling edge of start bit
        end
        s_start: begin
          // half a bit in, line must still be low
          if (baud_cnt == clks_per_bit / 2 - 1) begin
            baud_cnt <= '0;
            bit_idx <= '0;
            state <= rx_s ? s_idle : s_data;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        s_data: begin
          if (baud_cnt == clks_per_bit - 1) begin
            baud_cnt <= '0;
            if (bit_idx == 3'd7) state <= s_stop;
            bit_idx <= bit_idx + 1'b1;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: begin
          if (baud_cnt == clks_per_bit - 1) begin
            rx_valid <= rx_s;  // bad stop bit drops the byte
            state <= s_idle;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // lsb first, so shift in from the top
  always_ff @(posedge sys_clk) begin
    if (state == s_data && baud_cnt == clks_per_bit - 1) begin
      shift_reg <= {rx_s, shift_reg[7:1]};
    end
  end

endmodule

/* source/uart_tx.sv */
module uart_tx import host_pkg::*; (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_done
);

  logic [9:0] frame;    // stop, data, start; bit 0 is on the line
  logic [3:0] bit_cnt;
  logic busy;
  logic [$clog2(clks_per_bit)-1:0] baud_cnt;

  // ones shift in behind the frame, so the line rests high
  assign tx = frame[0];

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      frame <= '1;
      bit_cnt <= '0;
      busy <= 1'b0;
      baud_cnt <= '0;
      tx_done <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      if (!busy) begin
        if (tx_start) begin
          frame <= {1'b1, tx_byte, 1'b0};
          bit_cnt <= '0;
          baud_cnt <= '0;
          busy <= 1'b1;
        end
      end else if (baud_cnt == clks_per_bit - 1) begin
        baud_cnt <= '0;
        frame <= {1'b1, frame[9:1]};
        if (bit_cnt == 4'd9) begin
          // end of stop bit, hands the credit back
          busy <= 1'b0;
          tx_done <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

/* src.f */
+incdir+tests
source/host_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/program_loader.sv
source/mem_port_arbiter.sv
source/led_matrix_scan.sv
source/loader_top.sv
tests/tb_loader_top.sv

/* tests/tb_uart_tasks.svh */
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// random program words
logic [31:0] lcg_state = 32'hd678ff2f;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// start bit, 8 data bits lsb first, stop bit
task automatic send_byte(input logic [7:0] b);
  logic [9:0] frame;
  frame = {1'b1, b, 1'b0};
  for (int i = 0; i < 10; i++) begin
    rx_line = frame[i];
    repeat (clks_per_bit) @(posedge sys_clk);
    #2;
  end
endtask

task automatic send_word(input logic [15:0] w);
  send_byte(w[15:8]);  // high byte first
  send_byte(w[7:0]);
endtask

// ok is low if no frame starts or the stop bit is bad
task automatic recv_byte(output logic [7:0] b, output logic ok);
  int waited;
  waited = 0;
  ok = 1'b1;
  b = '0;
  while (tx_line !== 1'b0 && waited < 4 * clks_per_bit) begin
    @(negedge sys_clk);
    waited++;
  end
  if (tx_line !== 1'b0) begin
    ok = 1'b0;
  end else begin
    repeat (clks_per_bit / 2) @(negedge sys_clk);  // middle of start bit
    for (int i = 0; i < 8; i++) begin
      repeat (clks_per_bit) @(negedge sys_clk);
      b[i] = tx_line;
    end
    repeat (clks_per_bit) @(negedge sys_clk);
    if (tx_line !== 1'b1) ok = 1'b0;
  end
  @(posedge sys_clk);  // back to the drive point
  #2;
endtask

`endif

/* tests/tb_loader_top.sv */
module tb_loader_top import host_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period = 40;
  localparam int frame_clks = 10 * clks_per_bit;
  localparam int num_frames = 28;  // uart frames over all tests, with some slack
  localparam int watchdog_ns = num_frames * frame_clks * clk_period + 60000;

  logic sys_clk = 1'b0;
  logic rst_n;
  logic rx_line;
  logic tx_line;
  logic [7:0] led_col;
  logic [num_rows-1:0] led_row;
  wr_req_t cpu_req;
  logic [addr_width-1:0] cpu_rd_addr;
  mem_word_t cpu_rd_data;
  logic run;
  logic tx_credit;

  logic [15:0] words [0:7];  // loaded program
  string cur_test;
  int errors;
  int err_mark;
  int pass_cnt;
  int fail_cnt;

  `include "tb_uart_tasks.svh"

  always #(clk_period / 2) sys_clk = ~sys_clk;

  loader_top DUT (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .uart_rx    (rx_line),
    .uart_tx    (tx_line),
    .led_col    (led_col),
    .led_row    (led_row),
    .cpu_req    (cpu_req),
    .cpu_rd_addr(cpu_rd_addr),
    .cpu_rd_data(cpu_rd_data),
    .run        (run),
    .tx_credit  (tx_credit)
  );

  task automatic step();
    @(posedge sys_clk);
    #2;
  endtask

  task automatic expect_equal(input string what, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("error in %s: %s", cur_test, msg);
    errors++;
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic end_test();
    if (errors == err_mark) begin
      pass_cnt++;
      $display("test %s: passed", cur_test);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", cur_test, errors - err_mark);
    end
  endtask

  task automatic cpu_write(input logic [addr_width-1:0] a, input logic [15:0] d);
    cpu_req.valid = 1'b1;
    cpu_req.addr = a;
    cpu_req.data.word = d;
    step();
    cpu_req.valid = 1'b0;
  endtask

  // data is back one clock after the address
  task automatic cpu_read(input logic [addr_width-1:0] a, output logic [15:0] d);
    cpu_rd_addr = a;
    step();
    d = cpu_rd_data.word;
  endtask

  task automatic wait_credit();
    int n;
    n = 0;
    while (!tx_credit && n < frame_clks) begin
      step();
      n++;
    end
  endtask

  task automatic load_program();
    logic [31:0] r;
    logic [15:0] d;
    int n;
    begin_test("run_control");
    for (int i = 0; i < 8; i++) begin
      r = lcg_next();
      words[i] = (r[31:16] == end_word) ? 16'h1234 : r[31:16];
      send_word(words[i]);
      expect_equal("run during load", 16'd0, run);
    end
    repeat (4) step();
    cpu_write(load_base, ~words[0]);  // loader owns the ram, must be ignored
    expect_equal("run before terminator", 16'd0, run);
    send_word(end_word);
    n = 0;
    while (!run && n < frame_clks) begin
      step();
      n++;
    end
    expect_equal("run after terminator", 16'd1, run);
    cpu_read(load_base, d);
    expect_equal("word 0 after early cpu write", words[0], d);
    end_test();
  endtask

  task automatic check_readback();
    logic [15:0] d;
    begin_test("load");
    for (int i = 0; i < 8; i++) begin
      cpu_read(load_base + addr_width'(2 * i), d);
      expect_equal($sformatf("word %0d", i), words[i], d);
    end
    end_test();
  endtask

  task automatic cpu_access();
    logic [31:0] r;
    logic [15:0] d;
    begin_test("cpu_access");
    r = lcg_next();
    cpu_write(10'h3a0, r[31:16]);
    cpu_read(10'h3a0, d);
    expect_equal("written word", r[31:16], d);
    cpu_read(load_base + 10'd4, d);  // word the loader wrote
    expect_equal("loaded word", words[2], d);
    end_test();
  endtask

  task automatic io_port();
    logic [31:0] r;
    logic [15:0] d;
    logic [7:0] b;
    logic ok;
    begin_test("io_port");
    r = lcg_next();
    send_word(r[31:16]);
    repeat (4) step();
    cpu_read(io_addr, d);
    expect_equal("io read", r[31:16], d);
    cpu_write(io_addr, {8'h5a, r[7:0]});
    recv_byte(b, ok);
    if (!ok) report_error("no valid frame on uart_tx after the io write");
    expect_equal("tx byte", r[7:0], b);
    wait_credit();
    end_test();
  endtask

  task automatic credit_flow();
    logic [31:0] r;
    logic [7:0] b;
    logic ok;
    int n;
    begin_test("credit");
    r = lcg_next();
    expect_equal("credit before write", 16'd1, tx_credit);
    cpu_write(io_addr, {8'h00, r[7:0]});
    expect_equal("credit after write", 16'd0, tx_credit);
    // write held on while the credit is gone, every one dropped
    cpu_req.valid = 1'b1;
    cpu_req.addr = io_addr;
    cpu_req.data.word = {8'h00, r[15:8]};
    recv_byte(b, ok);
    if (!ok) report_error("no valid frame on uart_tx after the first write");
    expect_equal("first frame", r[7:0], b);
    wait_credit();
    cpu_req.valid = 1'b0;
    expect_equal("credit after frame", 16'd1, tx_credit);
    n = 0;
    repeat (frame_clks) begin
      @(negedge sys_clk);
      if (tx_line !== 1'b1) n++;
    end
    if (n != 0) report_error("uart_tx sent a frame for the write without credit");
    step();
    end_test();
  endtask

  task automatic display_rows();
    logic [31:0] r;
    int n;
    begin_test("display");
    r = lcg_next();
    cpu_write(10'h3c0, r[31:16]);
    for (int row = 0; row < 2; row++) begin
      n = 0;
      @(negedge sys_clk);
      while (led_row !== num_rows'(1 << row) && n < 2 * num_rows * row_period) begin
        @(negedge sys_clk);
        n++;
      end
      if (led_row !== num_rows'(1 << row))
        report_error($sformatf("row %0d was never lit", row));
      else if (row == 0)
        expect_equal("row 0 column", r[31:24], led_col);
      else
        expect_equal("row 1 column", r[23:16], led_col);
    end
    step();
    end_test();
  endtask

  // zero or one-hot, all the time
  always @(negedge sys_clk) begin
    if (rst_n === 1'b1) begin
      assert ((led_row & (led_row - 1'b1)) == '0) else begin
        $display("mismatch %s led_row: expected zero or one-hot, actual %b", cur_test, led_row);
        errors++;
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: run still going after %0d ns, stuck in test %s", watchdog_ns, cur_test);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    rx_line = 1'b1;  // uart idle
    cpu_req = '0;
    cpu_rd_addr = '0;
    errors = 0;
    err_mark = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    cur_test = "reset";
    repeat (10) @(posedge sys_clk);
    #2;
    rst_n = 1'b1;
    step();
    load_program();
    check_readback();
    cpu_access();
    io_port();
    credit_flow();
    display_rows();
    $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule
